// ==== hdl/lcd_config.svh ====
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

`define H_ACTIVE     96
`define H_TOTAL      120
`define HSYNC_START  100
`define HSYNC_END    108

`define V_ACTIVE     48
`define V_TOTAL      56
`define VSYNC_START  50
`define VSYNC_END    52

// image window, the stop values are exclusive
`define START_X      16
`define STOP_X       80
`define START_Y      8
`define STOP_Y       40

`define SCALE_SHIFT  2
`define IMG_WORDS    128

`endif

// ==== hdl/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

	typedef logic [15:0] coord_t; // pixel or line position
	typedef logic [6:0]  img_addr_t; // cell row in the upper 3 bits, cell column in the lower 4
	typedef logic [8:0]  img_word_t;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef struct packed {
		logic hsync; // active low
		logic vsync; // active low
		logic den;
	} sync_t;

	typedef enum logic [1:0] {
		LOAD_IDLE,
		LOAD_COPY,
		LOAD_DONE
	} load_state_t;

endpackage

`default_nettype wire

// ==== hdl/lcd_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_timing (
	input  logic            pixel_clk,
	input  logic            rst,
	output lcd_pkg::coord_t x,
	output lcd_pkg::coord_t y,
	output lcd_pkg::sync_t  timing_sync
);

	lcd_pkg::coord_t x_next;
	lcd_pkg::coord_t y_next;

	// sync levels that belong to one counter position
	function automatic lcd_pkg::sync_t sync_for(input lcd_pkg::coord_t px,
		input lcd_pkg::coord_t py);
		lcd_pkg::sync_t s;
		s.hsync = !((px >= `HSYNC_START) && (px < `HSYNC_END));
		s.vsync = !((py >= `VSYNC_START) && (py < `VSYNC_END));
		s.den   = (px < `H_ACTIVE) && (py < `V_ACTIVE);
		return s;
	endfunction

	always_comb begin
		x_next = x + 1'b1;
		y_next = y;
		if (x == lcd_pkg::coord_t'(`H_TOTAL - 1)) begin
			x_next = '0;
			if (y == lcd_pkg::coord_t'(`V_TOTAL - 1)) begin
				y_next = '0;
			end else begin
				y_next = y + 1'b1;
			end
		end
	end

	// the sync register is loaded from the next position so it stays in step with x and y
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			x           <= '0;
			y           <= '0;
			timing_sync <= sync_for('0, '0);
		end else begin
			x           <= x_next;
			y           <= y_next;
			timing_sync <= sync_for(x_next, y_next);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/image_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module image_rom (
	input  logic               pixel_clk,
	input  logic               rst,
	input  lcd_pkg::img_addr_t addr,
	output lcd_pkg::img_word_t data
);

	lcd_pkg::img_word_t word;

	// intensity pattern, the low 9 bits of addr times 37
	assign word = lcd_pkg::img_word_t'({2'b00, addr} * 9'd37);

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			data <= '0;
		end else begin
			data <= word;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/frame_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module frame_loader (
	input  logic               pixel_clk,
	input  logic               rst,
	output lcd_pkg::img_addr_t rom_addr,
	input  lcd_pkg::img_word_t rom_data,
	output logic               ram_we,
	output lcd_pkg::img_addr_t ram_waddr,
	output lcd_pkg::img_word_t ram_wdata
);

	lcd_pkg::load_state_t state;

	assign ram_we    = (state == lcd_pkg::LOAD_COPY);
	assign ram_wdata = rom_data; // the rom output is already one cycle behind rom_addr

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			state     <= lcd_pkg::LOAD_IDLE;
			rom_addr  <= '0;
			ram_waddr <= '0;
		end else begin
			case (state)
				lcd_pkg::LOAD_IDLE: begin
					state     <= lcd_pkg::LOAD_COPY; // word 0 is already being read
					rom_addr  <= rom_addr + 1'b1;
					ram_waddr <= rom_addr;
				end
				lcd_pkg::LOAD_COPY: begin
					rom_addr  <= rom_addr + 1'b1;
					ram_waddr <= rom_addr;
					if (ram_waddr == lcd_pkg::img_addr_t'(`IMG_WORDS - 1)) begin
						state <= lcd_pkg::LOAD_DONE;
					end
				end
				default: begin
					state <= lcd_pkg::LOAD_DONE; // stays here until the next reset
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/video_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module video_ram (
	input  logic               pixel_clk,
	input  logic               we,
	input  lcd_pkg::img_addr_t waddr,
	input  lcd_pkg::img_word_t wdata,
	input  lcd_pkg::img_addr_t raddr,
	output lcd_pkg::img_word_t rdata
);

	lcd_pkg::img_word_t mem [0:`IMG_WORDS-1];

	always_ff @(posedge pixel_clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// a read of the address being written returns the old word
	always_ff @(posedge pixel_clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// ==== hdl/pixel_compositor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module pixel_compositor (
	input  logic                pixel_clk,
	input  logic                rst,
	input  lcd_pkg::coord_t     x,
	input  lcd_pkg::coord_t     y,
	input  lcd_pkg::sync_t      timing_sync,
	output lcd_pkg::img_addr_t  ram_raddr,
	input  lcd_pkg::img_word_t  ram_rdata,
	output lcd_pkg::sync_t      lcd_sync,
	output lcd_pkg::rgb565_t    lcd_rgb
);

	lcd_pkg::coord_t        dx;
	lcd_pkg::coord_t        dy;
	lcd_pkg::coord_t        cell_col;
	lcd_pkg::coord_t        cell_row;
	logic                   in_win;
	logic                   in_win_s1;
	logic                   in_win_s2;
	lcd_pkg::coord_t        grad_s1;
	lcd_pkg::coord_t        grad_s2;
	lcd_pkg::sync_t [1:0]   sync_pipe;
	lcd_pkg::rgb565_t       pixel_rgb;

	function automatic lcd_pkg::rgb565_t expand_word(input lcd_pkg::img_word_t w);
		lcd_pkg::rgb565_t c;
		c.r = w[8:4];
		c.g = w[8:3];
		c.b = w[8:4];
		return c;
	endfunction

	function automatic lcd_pkg::rgb565_t expand_grad(input lcd_pkg::coord_t v);
		lcd_pkg::rgb565_t c;
		c.r = v[4:0];
		c.g = v[10:5];
		c.b = v[15:11];
		return c;
	endfunction

	assign in_win   = (x >= `START_X) && (x < `STOP_X) && (y >= `START_Y) && (y < `STOP_Y);
	assign dx       = x - lcd_pkg::coord_t'(`START_X);
	assign dy       = y - lcd_pkg::coord_t'(`START_Y);
	assign cell_col = dx >> `SCALE_SHIFT;
	assign cell_row = dy >> `SCALE_SHIFT;

	// stage 1 registers the address, stage 2 carries the rest while the ram reads
	always_ff @(posedge pixel_clk) begin
		ram_raddr <= {cell_row[2:0], cell_col[3:0]};
		in_win_s1 <= in_win;
		grad_s1   <= x + y;
		in_win_s2 <= in_win_s1;
		grad_s2   <= grad_s1;
	end

	always_comb begin
		pixel_rgb = '0;
		if (sync_pipe[1].den) begin
			pixel_rgb = in_win_s2 ? expand_word(ram_rdata) : expand_grad(grad_s2);
		end
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			sync_pipe[0] <= '{hsync: 1'b1, vsync: 1'b1, den: 1'b0};
			sync_pipe[1] <= '{hsync: 1'b1, vsync: 1'b1, den: 1'b0};
			lcd_sync     <= '{hsync: 1'b1, vsync: 1'b1, den: 1'b0};
			lcd_rgb      <= '0;
		end else begin
			sync_pipe <= {sync_pipe[0], timing_sync}; // three pixels in flight
			lcd_sync  <= sync_pipe[1];
			lcd_rgb   <= pixel_rgb;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/lcd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_top (
	input  logic             pixel_clk,
	input  logic             rst,
	output lcd_pkg::sync_t   lcd_sync,
	output lcd_pkg::rgb565_t lcd_rgb
);

	lcd_pkg::coord_t    x;
	lcd_pkg::coord_t    y;
	lcd_pkg::sync_t     timing_sync;
	lcd_pkg::img_addr_t rom_addr;
	lcd_pkg::img_word_t rom_data;
	logic               ram_we;
	lcd_pkg::img_addr_t ram_waddr;
	lcd_pkg::img_word_t ram_wdata;
	lcd_pkg::img_addr_t ram_raddr;
	lcd_pkg::img_word_t ram_rdata;

	lcd_timing timing (
		.pixel_clk   (pixel_clk),
		.rst         (rst),
		.x           (x),
		.y           (y),
		.timing_sync (timing_sync)
	);

	image_rom rom (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.addr      (rom_addr),
		.data      (rom_data)
	);

	frame_loader loader (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.rom_addr  (rom_addr),
		.rom_data  (rom_data),
		.ram_we    (ram_we),
		.ram_waddr (ram_waddr),
		.ram_wdata (ram_wdata)
	);

	video_ram vram (
		.pixel_clk (pixel_clk),
		.we        (ram_we),
		.waddr     (ram_waddr),
		.wdata     (ram_wdata),
		.raddr     (ram_raddr),
		.rdata     (ram_rdata)
	);

	pixel_compositor compositor (
		.pixel_clk   (pixel_clk),
		.rst         (rst),
		.x           (x),
		.y           (y),
		.timing_sync (timing_sync),
		.ram_raddr   (ram_raddr),
		.ram_rdata   (ram_rdata),
		.lcd_sync    (lcd_sync),
		.lcd_rgb     (lcd_rgb)
	);

endmodule

`default_nettype wire

// ==== sim/lcd_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_assertions (
	input logic                 pixel_clk,
	input logic                 rst,
	input logic                 ram_we,
	input lcd_pkg::load_state_t load_state,
	input lcd_pkg::sync_t       lcd_sync,
	input lcd_pkg::rgb565_t     lcd_rgb
);

	localparam int HSYNC_LEN = `HSYNC_END - `HSYNC_START;

	int unsigned failures = 0;

	// one write burst covers every image word and leaves the loader in LOAD_DONE
	we_burst_length: assert property (@(posedge pixel_clk) disable iff (!rst)
		$rose(ram_we) |-> ##`IMG_WORDS ($fell(ram_we) && load_state == lcd_pkg::LOAD_DONE))
	else begin
		$error("ram_we is not high for exactly %0d cycles before LOAD_DONE", `IMG_WORDS);
		failures++;
	end

	// a falling hsync must rise again after exactly one pulse width
	hsync_width: assert property (@(posedge pixel_clk) disable iff (!rst)
		$fell(lcd_sync.hsync) |-> ##HSYNC_LEN $rose(lcd_sync.hsync))
	else begin
		$error("hsync pulse is not %0d cycles long", HSYNC_LEN);
		failures++;
	end

	blank_without_den: assert property (@(posedge pixel_clk) disable iff (!rst)
		!lcd_sync.den |-> lcd_rgb == '0)
	else begin
		$error("lcd_rgb is not zero while den is low");
		failures++;
	end

endmodule

bind lcd_top lcd_assertions sva (
	.pixel_clk  (pixel_clk),
	.rst        (rst),
	.ram_we     (ram_we),
	.load_state (loader.state),
	.lcd_sync   (lcd_sync),
	.lcd_rgb    (lcd_rgb)
);

`default_nettype wire

// ==== sim/lcd_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_checker (
	input  logic             pixel_clk,
	input  logic             rst,
	input  lcd_pkg::sync_t   lcd_sync,
	input  lcd_pkg::rgb565_t lcd_rgb,
	output logic             done,
	output int unsigned      failed_tests
);

	localparam int NUM_VECTORS  = 14;
	localparam int LATENCY      = 3; // from a counter step to the panel outputs
	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam lcd_pkg::sync_t IDLE_SYNC = '{hsync: 1'b1, vsync: 1'b1, den: 1'b0};

	logic [47:0] vectors [0:NUM_VECTORS-1]; // x, y and rgb565 in one word
	int          cycle;
	int unsigned checks [0:4]; // sync, image window, background, blanking, reset
	int unsigned errors [0:4];
	int unsigned tests_run;

	function automatic lcd_pkg::sync_t expected_sync(input int px, input int py);
		lcd_pkg::sync_t s;
		s.hsync = (px < `HSYNC_START) || (px >= `HSYNC_END);
		s.vsync = (py < `VSYNC_START) || (py >= `VSYNC_END);
		s.den   = (px < `H_ACTIVE) && (py < `V_ACTIVE);
		return s;
	endfunction

	function automatic bit in_window(input int px, input int py);
		return (px >= `START_X) && (px < `STOP_X) && (py >= `START_Y) && (py < `STOP_Y);
	endfunction

	task automatic end_test(input string name, input int t);
		tests_run++;
		if (errors[t] == 0) begin
			$display("test %s: passed, %0d checks", name, checks[t]);
		end else begin
			failed_tests++;
			$display("test %s: failed, %0d errors in %0d checks", name, errors[t], checks[t]);
		end
		checks[t] = 0;
		errors[t] = 0;
	endtask

	task automatic close_frame(input int frame);
		int unsigned want_hits [1:2];
		want_hits[1] = 0;
		want_hits[2] = 0;
		for (int i = 0; i < NUM_VECTORS; i++) begin
			if (in_window(int'(vectors[i][47:32]), int'(vectors[i][31:16]))) begin
				want_hits[1]++;
			end else begin
				want_hits[2]++;
			end
		end
		for (int t = 1; t <= 2; t++) begin
			if (checks[t] != want_hits[t]) begin
				$display("Only %0d of %0d vectors were reached in frame %0d", checks[t],
					want_hits[t], frame);
				errors[t]++;
			end
		end
		end_test($sformatf("sync, frame %0d", frame), 0);
		end_test($sformatf("image window, frame %0d", frame), 1);
		end_test($sformatf("background, frame %0d", frame), 2);
		end_test($sformatf("blanking, frame %0d", frame), 3);
	endtask

	task automatic reset_levels();
		checks[4]++;
		if (lcd_sync !== IDLE_SYNC) begin
			errors[4]++;
			$display("Fail lcd_sync in reset: expected %h, got %h", IDLE_SYNC, lcd_sync);
		end
		if (lcd_rgb !== '0) begin
			errors[4]++;
			$display("Fail lcd_rgb in reset: expected 0000, got %h", lcd_rgb);
		end
	endtask

	task automatic compare_sample(input int step);
		int             px;
		int             py;
		int             t;
		lcd_pkg::sync_t want;
		px   = (step % FRAME_CYCLES) % `H_TOTAL;
		py   = (step % FRAME_CYCLES) / `H_TOTAL;
		want = expected_sync(px, py);
		checks[0]++;
		if (lcd_sync !== want) begin
			errors[0]++;
			$display("Fail lcd_sync at (%0d,%0d): expected %h, got %h", px, py, want, lcd_sync);
		end
		if (!lcd_sync.den) begin
			checks[3]++;
			if (lcd_rgb !== '0) begin
				errors[3]++;
				$display("Fail lcd_rgb at (%0d,%0d) with den low: expected 0000, got %h",
					px, py, lcd_rgb);
			end
		end
		for (int i = 0; i < NUM_VECTORS; i++) begin
			if (int'(vectors[i][47:32]) == px && int'(vectors[i][31:16]) == py) begin
				t = in_window(px, py) ? 1 : 2;
				checks[t]++;
				if (lcd_rgb !== vectors[i][15:0]) begin
					errors[t]++;
					$display("Fail lcd_rgb at (%0d,%0d): expected %h, got %h", px, py,
						vectors[i][15:0], lcd_rgb);
				end
			end
		end
	endtask

	initial begin
		done         = 1'b0;
		failed_tests = 0;
		tests_run    = 0;
		cycle        = 0;
		for (int t = 0; t < 5; t++) begin
			checks[t] = 0;
			errors[t] = 0;
		end
		$readmemh("sim/lcd_vectors.txt", vectors);
	end

	always @(posedge pixel_clk) begin
		if (rst) begin
			cycle++; // rising edges since reset release
		end
	end

	// outputs only move on the rising edge, so the falling edge sees them settled
	always @(negedge pixel_clk) begin
		if (!done && cycle < LATENCY) begin
			reset_levels();
		end else if (!done) begin
			if (cycle == LATENCY) begin
				end_test("reset", 4);
			end
			compare_sample(cycle - LATENCY);
			if ((cycle - LATENCY) % FRAME_CYCLES == FRAME_CYCLES - 1) begin
				close_frame((cycle - LATENCY) / FRAME_CYCLES + 1);
			end
			if (cycle - LATENCY == 2 * FRAME_CYCLES - 1) begin
				$display("%0d tests run, %0d passed, %0d failed", tests_run,
					tests_run - failed_tests, failed_tests);
				done = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/lcd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_tb;

	localparam int CYCLE_LIMIT = 2 * `H_TOTAL * `V_TOTAL + 200; // two frames and some margin

	logic             pixel_clk;
	logic             rst;
	lcd_pkg::sync_t   lcd_sync;
	lcd_pkg::rgb565_t lcd_rgb;
	logic             done;
	int unsigned      failed_tests;
	int unsigned      cycles;

	lcd_top dut (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.lcd_sync  (lcd_sync),
		.lcd_rgb   (lcd_rgb)
	);

	lcd_checker check (
		.pixel_clk    (pixel_clk),
		.rst          (rst),
		.lcd_sync     (lcd_sync),
		.lcd_rgb      (lcd_rgb),
		.done         (done),
		.failed_tests (failed_tests)
	);

	initial pixel_clk = 1'b0;

	always #10 pixel_clk = ~pixel_clk;

	initial begin
		rst    = 1'b0;
		cycles = 0;
		repeat (3) @(posedge pixel_clk);
		@(negedge pixel_clk);
		rst = 1'b1; // released between two rising edges
		while (!done && cycles < CYCLE_LIMIT) begin
			@(posedge pixel_clk);
			cycles++;
		end
		if (!done) begin
			$display("Timeout after %0d cycles, the checker never finished its tests", cycles);
			$display(">>> FAIL");
		end else if (failed_tests == 0 && dut.sva.failures == 0) begin
			$display(">>> PASS");
		end else begin
			$display("%0d tests failed and %0d assertions failed", failed_tests,
				dut.sva.failures);
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/lcd_vectors.txt ====
// each word is x, y and the expected rgb565, four hex digits each
// window cells first, then the background next to the window edges
001000080000 // window top left, address 0
004f00272965 // window bottom right, address 127
004f000810a2 // window top right, address 15
0010002718c3 // window bottom left, address 112
001300080000 // last pixel of cell 0
001400081082 // first pixel of cell 1
0010000c2945 // first line of cell row 1, address 16
0032001931a6 // window middle, address 72
000f0008b800 // left of the window
00500027b860 // right of the window
002800077820 // above the window
001e00283040 // below the window
000000000000 // first active pixel
005f002f7080 // last active pixel

// ==== sim.f ====
+incdir+hdl
hdl/lcd_pkg.sv
hdl/lcd_timing.sv
hdl/image_rom.sv
hdl/frame_loader.sv
hdl/video_ram.sv
hdl/pixel_compositor.sv
hdl/lcd_top.sv
sim/lcd_assertions.sv
sim/lcd_checker.sv
sim/lcd_tb.sv

// ==== Makefile ====
TOP = lcd_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir
